//--- adc_ctrl.f
design/adc_ctrl_pkg.sv
design/sysref_gen.sv
design/spi_3wire_master.sv
design/spi_arbiter.sv
design/adc_init_seq.sv
design/adc_ctrl_top.sv
bench/adc_spi_model.sv
bench/tb_adc_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ADC control testbench with Verilator
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_adc_ctrl -f adc_ctrl.f -o tb_adc_ctrl_sim &&
./obj_dir/tb_adc_ctrl_sim | tee sim.log ||
echo "Build or simulation step failed"
grep -qx "All tests passed!" sim.log && echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }

//--- bench/tb_adc_ctrl.sv
/*
 * ADC control testbench
 * Runs the init table, host writes and reads, arbitration against the
 * init sequencer, SPI pin turnaround and SYSREF timing against a
 * behavioural converter SPI slave.
 */

`timescale 1ns/1ps

module tb_adc_ctrl;

  localparam int FRAME_CYCLES =
    2 + adc_ctrl_pkg::SPI_FRAME_BITS * 2 * adc_ctrl_pkg::SPI_CLK_DIV;
  localparam int CSN_LOW_CYCLES  = FRAME_CYCLES - 2;
  localparam int RD_FREE_CYCLES  = adc_ctrl_pkg::SPI_DATA_BITS * 2 * adc_ctrl_pkg::SPI_CLK_DIV;
  localparam int TIMEOUT_CYCLES  = 30 * FRAME_CYCLES + 500;
  localparam int EXPECTED_FRAMES = adc_ctrl_pkg::INIT_COUNT + 3;

  logic                    sys_clk_i = 1'b0;
  logic                    reset_i;
  logic                    host_valid_i;
  adc_ctrl_pkg::spi_req_t  host_req_i;
  logic                    host_done_o;
  adc_ctrl_pkg::spi_data_t host_rdata_o;
  logic                    init_done_o;
  logic                    sysref_en_i;
  logic                    sysref_o;
  logic                    spi_csn_o;
  logic                    spi_clk_o;
  logic                    spi_sdo_o;
  logic                    spi_sdo_en_o;
  logic                    spi_sd;
  logic                    model_sdo;
  logic                    model_sdo_en;

  int cyc            = 0;
  int init_done_cyc  = -1;
  int init_writes    = 0;
  int frame_errs     = 0;
  int pin_errs       = 0;
  int contention_errs = 0;
  int frames_seen    = 0;
  int reads_seen     = 0;
  int low_cyc        = 0;
  int en_low_cyc     = 0;
  int tests_passed   = 0;
  int tests_failed   = 0;

  always #10 sys_clk_i = ~sys_clk_i;

  // Shared data pin with a pull-up when nobody drives it
  assign spi_sd = spi_sdo_en_o ? spi_sdo_o : (model_sdo_en ? model_sdo : 1'b1);

  adc_ctrl_top adc_ctrl_top_inst (
    .sys_clk_i    (sys_clk_i),
    .reset_i      (reset_i),
    .host_valid_i (host_valid_i),
    .host_req_i   (host_req_i),
    .host_done_o  (host_done_o),
    .host_rdata_o (host_rdata_o),
    .init_done_o  (init_done_o),
    .sysref_en_i  (sysref_en_i),
    .sysref_o     (sysref_o),
    .spi_csn_o    (spi_csn_o),
    .spi_clk_o    (spi_clk_o),
    .spi_sdo_o    (spi_sdo_o),
    .spi_sdo_en_o (spi_sdo_en_o),
    .spi_sdi_i    (spi_sd)
  );

  adc_spi_model adc_spi_model_inst (
    .spi_csn_i (spi_csn_o),
    .spi_clk_i (spi_clk_o),
    .spi_sd_i  (spi_sd),
    .sdo_o     (model_sdo),
    .sdo_en_o  (model_sdo_en)
  );

  // **************************************************
  // Monitors and assertions
  // **************************************************
  always @(posedge sys_clk_i) begin
    cyc = cyc + 1;
    if (cyc > TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  idle_pins_chk: assert property (@(posedge sys_clk_i) disable iff (reset_i)
    spi_csn_o |-> (spi_clk_o && !spi_sdo_en_o))
    else begin
      pin_errs++;
      $display("SPI clock or data enable active outside a frame at cycle %0d", cyc);
    end

  contention_chk: assert property (@(posedge sys_clk_i) disable iff (reset_i)
    !(spi_sdo_en_o && model_sdo_en))
    else begin
      contention_errs++;
      $display("Master and slave both drive the data pin at cycle %0d", cyc);
    end

  // Frame length and data pin release per frame
  always @(posedge sys_clk_i) begin
    if (reset_i) begin
      low_cyc    = 0;
      en_low_cyc = 0;
    end else if (!spi_csn_o) begin
      low_cyc = low_cyc + 1;
      if (!spi_sdo_en_o) begin
        en_low_cyc = en_low_cyc + 1;
      end
    end else if (low_cyc != 0) begin
      frames_seen = frames_seen + 1;
      if (adc_spi_model_inst.frame_rnw) begin
        reads_seen = reads_seen + 1;
      end
      assert (low_cyc == CSN_LOW_CYCLES) else begin
        frame_errs++;
        $display("FAILED frame_length: expected %0d, actual %0d", CSN_LOW_CYCLES, low_cyc);
      end
      assert (en_low_cyc == (adc_spi_model_inst.frame_rnw ? RD_FREE_CYCLES : 0)) else begin
        frame_errs++;
        $display("FAILED pin_release: expected %0d, actual %0d",
                 adc_spi_model_inst.frame_rnw ? RD_FREE_CYCLES : 0, en_low_cyc);
      end
      low_cyc    = 0;
      en_low_cyc = 0;
    end
  end

  always @(negedge sys_clk_i) begin
    if (!reset_i && init_done_o && init_done_cyc < 0) begin
      init_done_cyc = cyc;
      init_writes   = adc_spi_model_inst.wr_count;
    end
  end

  // **************************************************
  // Helpers
  // **************************************************
  task automatic check_value(input string name, input int expected, input int actual,
                             inout int fails);
    assert (expected == actual) else begin
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      fails++;
    end
  endtask

  task automatic report_test(input string name, input int fails);
    if (fails == 0) begin
      $display("PASS %s", name);
      tests_passed++;
    end else begin
      $display("FAIL %s with %0d failing checks", name, fails);
      tests_failed++;
    end
  endtask

  // One host strobe and its latency from strobe to done
  task automatic host_access(input adc_ctrl_pkg::spi_req_t req, output int lat,
                             output adc_ctrl_pkg::spi_data_t rdata, output int done_cyc);
    int t0;
    @(posedge sys_clk_i);
    #1;
    host_valid_i = 1'b1;
    host_req_i   = req;
    t0           = cyc;
    @(posedge sys_clk_i);
    #1;
    host_valid_i = 1'b0;
    lat          = -1;
    while (lat < 0) begin
      @(negedge sys_clk_i);
      if (host_done_o) begin
        lat      = cyc - t0;
        rdata    = host_rdata_o;
        done_cyc = cyc;
      end
    end
  endtask

  task automatic wait_sysref(input logic level, output int at_cyc);
    @(negedge sys_clk_i);
    while (sysref_o != level) begin
      @(negedge sys_clk_i);
    end
    at_cyc = cyc;
  endtask

  // **************************************************
  // Stimulus
  // **************************************************
  initial begin
    adc_ctrl_pkg::spi_addr_t taddr;
    adc_ctrl_pkg::spi_data_t wdata;
    adc_ctrl_pkg::spi_data_t rdata;
    adc_ctrl_pkg::spi_data_t arb_data;
    int lat;
    int done_cyc;
    int t_start;
    int t_rise;
    int t_fall;
    int t_next;
    int highs;
    int fails;

    reset_i      = 1'b1;
    host_valid_i = 1'b0;
    host_req_i   = '0;
    sysref_en_i  = 1'b0;
    void'($urandom(32'h08eb7da7));
    repeat (2) @(posedge sys_clk_i);
    #1;
    reset_i = 1'b0;

    // Host write lands in the middle of the first init frame
    repeat (10) @(posedge sys_clk_i);
    arb_data = 8'($urandom());
    host_access('{1'b0, 15'h0120, arb_data}, lat, rdata, done_cyc);

    fails = 0;
    for (int i = 0; i < adc_ctrl_pkg::INIT_COUNT; i++) begin
      check_value("init_table_value", int'(adc_ctrl_pkg::INIT_TABLE[i].wdata),
                  int'(adc_spi_model_inst.regs[adc_ctrl_pkg::INIT_TABLE[i].addr[7:0]]), fails);
    end
    check_value("init_write_count", adc_ctrl_pkg::INIT_COUNT, init_writes, fails);
    report_test("init_table", fails);

    fails = 0;
    check_value("arb_host_after_init", 1, int'(init_done_cyc >= 0 && done_cyc > init_done_cyc),
                fails);
    check_value("arb_host_data", int'(arb_data), int'(adc_spi_model_inst.regs[8'h20]), fails);
    report_test("arbitration", fails);

    fails = 0;
    repeat (4) @(posedge sys_clk_i);
    taddr = 15'($urandom());
    wdata = 8'($urandom());
    host_access('{1'b0, taddr, wdata}, lat, rdata, done_cyc);
    check_value("host_write_latency", FRAME_CYCLES, lat, fails);
    check_value("host_write_data", int'(wdata), int'(adc_spi_model_inst.regs[taddr[7:0]]), fails);
    host_access('{1'b1, taddr, 8'h00}, lat, rdata, done_cyc);
    check_value("host_read_latency", FRAME_CYCLES, lat, fails);
    check_value("host_read_data", int'(wdata), int'(rdata), fails);
    report_test("host_write_read", fails);

    // SYSREF phase restarts from the enable
    fails = 0;
    @(posedge sys_clk_i);
    #1;
    sysref_en_i = 1'b1;
    t_start     = cyc;
    wait_sysref(1'b1, t_rise);
    check_value("sysref_first_rise", adc_ctrl_pkg::SYSREF_HALF, t_rise - t_start, fails);
    for (int p = 0; p < 3; p++) begin
      wait_sysref(1'b0, t_fall);
      check_value("sysref_high_time", adc_ctrl_pkg::SYSREF_HALF, t_fall - t_rise, fails);
      wait_sysref(1'b1, t_next);
      check_value("sysref_period", adc_ctrl_pkg::SYSREF_PERIOD, t_next - t_rise, fails);
      t_rise = t_next;
    end
    @(posedge sys_clk_i);
    #1;
    sysref_en_i = 1'b0;
    // Enable is sampled low at the next edge
    @(posedge sys_clk_i);
    @(negedge sys_clk_i);
    check_value("sysref_drop", 0, int'(sysref_o), fails);
    highs = 0;
    repeat (2 * adc_ctrl_pkg::SYSREF_PERIOD) begin
      @(negedge sys_clk_i);
      if (sysref_o) begin
        highs++;
      end
    end
    check_value("sysref_held_low", 0, highs, fails);
    report_test("sysref", fails);

    // Pin monitors cover the whole run
    fails = frame_errs + pin_errs + contention_errs;
    check_value("frame_count", EXPECTED_FRAMES, frames_seen, fails);
    check_value("read_frame_count", 1, reads_seen, fails);
    report_test("pin_turnaround", fails);

    $display("Tests run: %0d, passed: %0d, failed: %0d",
             tests_passed + tests_failed, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- bench/adc_spi_model.sv
/*
 * Converter SPI slave model
 * Decodes three wire frames (rnw, address, data) on the pins and keeps
 * a 256 entry register array indexed by the low address bits. It drives
 * the shared data pin during the data phase of a read.
 */

`timescale 1ns/1ps

module adc_spi_model (
  input  logic spi_csn_i,
  input  logic spi_clk_i,
  input  logic spi_sd_i,
  output logic sdo_o,
  output logic sdo_en_o
);

  // One entry per value of the low address byte
  adc_ctrl_pkg::spi_data_t  regs [256];
  adc_ctrl_pkg::spi_frame_t rx_q;
  adc_ctrl_pkg::spi_data_t  tx_q;
  adc_ctrl_pkg::spi_addr_t  addr_q;
  logic                     frame_rnw;
  int                       bit_cnt;
  int                       wr_count;

  initial begin
    for (int i = 0; i < 256; i++) begin
      regs[i] = 8'(i) ^ 8'h5a;
    end
    rx_q      = '0;
    tx_q      = '0;
    addr_q    = '0;
    frame_rnw = 1'b0;
    bit_cnt   = 0;
    wr_count  = 0;
    sdo_o     = 1'b1;
    sdo_en_o  = 1'b0;
  end

  // Capture on the rising SPI clock, header complete after 16 bits
  always @(posedge spi_clk_i) begin
    if (!spi_csn_i) begin
      rx_q    = {rx_q[adc_ctrl_pkg::SPI_FRAME_BITS-2:0], spi_sd_i};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 16) begin
        frame_rnw = rx_q[15];
        addr_q    = rx_q[14:0];
        tx_q      = regs[addr_q[7:0]];
      end
    end
  end

  // Read data goes out on the falling edge
  always @(negedge spi_clk_i) begin
    if (!spi_csn_i && frame_rnw && bit_cnt >= 16) begin
      sdo_en_o = 1'b1;
      sdo_o    = tx_q[adc_ctrl_pkg::SPI_DATA_BITS-1];
      tx_q     = {tx_q[adc_ctrl_pkg::SPI_DATA_BITS-2:0], 1'b0};
    end
  end

  // End of frame, commit complete writes
  always @(posedge spi_csn_i) begin
    sdo_en_o = 1'b0;
    if (bit_cnt == adc_ctrl_pkg::SPI_FRAME_BITS && !frame_rnw) begin
      regs[addr_q[7:0]] = rx_q[7:0];
      wr_count          = wr_count + 1;
    end
    bit_cnt = 0;
  end

endmodule

//--- design/adc_ctrl_top.sv
/*
 * ADC control top
 * Converter SPI configuration through a shared three wire engine, fed by
 * the init sequencer and the host command port, plus the SYSREF output.
 */

`timescale 1ns/1ps

module adc_ctrl_top (
  input  logic                    sys_clk_i,
  input  logic                    reset_i,
  input  logic                    host_valid_i,
  input  adc_ctrl_pkg::spi_req_t  host_req_i,
  output logic                    host_done_o,
  output adc_ctrl_pkg::spi_data_t host_rdata_o,
  output logic                    init_done_o,
  input  logic                    sysref_en_i,
  output logic                    sysref_o,
  output logic                    spi_csn_o,
  output logic                    spi_clk_o,
  output logic                    spi_sdo_o,
  output logic                    spi_sdo_en_o,
  input  logic                    spi_sdi_i
);

  logic                    seq_valid;
  adc_ctrl_pkg::spi_req_t  seq_req;
  logic                    seq_done;
  logic                    eng_start;
  adc_ctrl_pkg::spi_req_t  eng_req;
  logic                    eng_busy;
  logic                    eng_done;
  adc_ctrl_pkg::spi_data_t eng_rdata;

  // **************************************************
  // SPI requesters and arbitration
  // **************************************************
  adc_init_seq adc_init_seq_inst (
    .sys_clk_i   (sys_clk_i),
    .reset_i     (reset_i),
    .valid_o     (seq_valid),
    .req_o       (seq_req),
    .done_i      (seq_done),
    .init_done_o (init_done_o)
  );

  spi_arbiter spi_arbiter_inst (
    .sys_clk_i    (sys_clk_i),
    .reset_i      (reset_i),
    .seq_valid_i  (seq_valid),
    .seq_req_i    (seq_req),
    .seq_done_o   (seq_done),
    .host_valid_i (host_valid_i),
    .host_req_i   (host_req_i),
    .host_done_o  (host_done_o),
    .host_rdata_o (host_rdata_o),
    .eng_start_o  (eng_start),
    .eng_req_o    (eng_req),
    .eng_busy_i   (eng_busy),
    .eng_done_i   (eng_done),
    .eng_rdata_i  (eng_rdata)
  );

  // SPI engine owns the converter pins
  spi_3wire_master spi_3wire_master_inst (
    .sys_clk_i    (sys_clk_i),
    .reset_i      (reset_i),
    .start_i      (eng_start),
    .req_i        (eng_req),
    .done_o       (eng_done),
    .rdata_o      (eng_rdata),
    .busy_o       (eng_busy),
    .spi_csn_o    (spi_csn_o),
    .spi_clk_o    (spi_clk_o),
    .spi_sdo_o    (spi_sdo_o),
    .spi_sdo_en_o (spi_sdo_en_o),
    .spi_sdi_i    (spi_sdi_i)
  );

  sysref_gen sysref_gen_inst (
    .sys_clk_i   (sys_clk_i),
    .reset_i     (reset_i),
    .sysref_en_i (sysref_en_i),
    .sysref_o    (sysref_o)
  );

endmodule

//--- design/adc_init_seq.sv
/*
 * ADC init sequencer
 * Writes the converter init table after reset, one request at a time,
 * and holds init_done_o high once the last write has completed.
 */

`timescale 1ns/1ps

module adc_init_seq (
  input  logic                   sys_clk_i,
  input  logic                   reset_i,
  output logic                   valid_o,
  output adc_ctrl_pkg::spi_req_t req_o,
  input  logic                   done_i,
  output logic                   init_done_o
);

  adc_ctrl_pkg::init_state_e state_q;
  adc_ctrl_pkg::init_idx_t   idx_q;
  logic                      valid_q;

  // **************************************************
  // Table walk
  // **************************************************
  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      state_q <= adc_ctrl_pkg::ISSUE;
      idx_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        adc_ctrl_pkg::ISSUE: begin
          valid_q <= 1'b1;
          state_q <= adc_ctrl_pkg::WAIT;
        end
        adc_ctrl_pkg::WAIT: begin
          if (done_i) begin
            if (idx_q == adc_ctrl_pkg::INIT_LAST) begin
              state_q <= adc_ctrl_pkg::FINISHED;
            end else begin
              // Next entry strobes right after done
              idx_q   <= idx_q + 1'b1;
              valid_q <= 1'b1;
            end
          end
        end
        adc_ctrl_pkg::FINISHED: begin
          state_q <= adc_ctrl_pkg::FINISHED;
        end
        default: begin
          state_q <= adc_ctrl_pkg::ISSUE;
        end
      endcase
    end
  end

  assign valid_o     = valid_q;
  assign req_o       = adc_ctrl_pkg::INIT_TABLE[idx_q];
  assign init_done_o = (state_q == adc_ctrl_pkg::FINISHED);

endmodule

//--- design/spi_arbiter.sv
/*
 * SPI request arbiter
 * Shares the SPI engine between the init sequencer and the host port.
 * Fixed priority with the sequencer first; done and read data go back
 * to the peer that owns the frame in progress.
 */

`timescale 1ns/1ps

module spi_arbiter (
  input  logic                    sys_clk_i,
  input  logic                    reset_i,
  input  logic                    seq_valid_i,
  input  adc_ctrl_pkg::spi_req_t  seq_req_i,
  output logic                    seq_done_o,
  input  logic                    host_valid_i,
  input  adc_ctrl_pkg::spi_req_t  host_req_i,
  output logic                    host_done_o,
  output adc_ctrl_pkg::spi_data_t host_rdata_o,
  output logic                    eng_start_o,
  output adc_ctrl_pkg::spi_req_t  eng_req_o,
  input  logic                    eng_busy_i,
  input  logic                    eng_done_i,
  input  adc_ctrl_pkg::spi_data_t eng_rdata_i
);

  adc_ctrl_pkg::spi_req_t seq_req_q;
  adc_ctrl_pkg::spi_req_t host_req_q;
  adc_ctrl_pkg::spi_req_t seq_req_sel;
  adc_ctrl_pkg::spi_req_t host_req_sel;
  logic                   seq_pend_q;
  logic                   host_pend_q;
  logic                   inflight_q;
  logic                   owner_host_q;
  logic                   seq_want;
  logic                   host_want;
  logic                   eng_free;
  logic                   grant_seq;
  logic                   grant_host;

  // A fresh strobe is visible in the same cycle as a pending slot
  assign seq_want     = seq_pend_q | seq_valid_i;
  assign host_want    = host_pend_q | host_valid_i;
  assign seq_req_sel  = seq_pend_q ? seq_req_q : seq_req_i;
  assign host_req_sel = host_pend_q ? host_req_q : host_req_i;

  // Held off through the done cycle so the sequencer can follow up first
  assign eng_free   = !inflight_q && !eng_busy_i;
  assign grant_seq  = eng_free && seq_want;
  assign grant_host = eng_free && host_want && !seq_want;

  assign eng_start_o = grant_seq | grant_host;
  assign eng_req_o   = grant_seq ? seq_req_sel : host_req_sel;

  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      seq_pend_q   <= 1'b0;
      host_pend_q  <= 1'b0;
      inflight_q   <= 1'b0;
      owner_host_q <= 1'b0;
    end else begin
      seq_pend_q  <= seq_want && !grant_seq;
      host_pend_q <= host_want && !grant_host;
      if (eng_start_o) begin
        inflight_q   <= 1'b1;
        owner_host_q <= grant_host;
      end else if (eng_done_i) begin
        inflight_q <= 1'b0;
      end
    end
  end

  // Request payload slots
  always_ff @(posedge sys_clk_i) begin
    if (seq_valid_i) begin
      seq_req_q <= seq_req_i;
    end
    if (host_valid_i) begin
      host_req_q <= host_req_i;
    end
  end

  assign seq_done_o   = eng_done_i && inflight_q && !owner_host_q;
  assign host_done_o  = eng_done_i && inflight_q && owner_host_q;
  assign host_rdata_o = eng_rdata_i;

endmodule

//--- design/spi_3wire_master.sv
/*
 * Three wire SPI master
 * Sends one 24 bit frame (rnw, address, data) MSB first over a shared
 * data pin. For reads the pin is released after the address phase and
 * the last 8 bits are sampled into rdata_o.
 */

`timescale 1ns/1ps

module spi_3wire_master (
  input  logic                    sys_clk_i,
  input  logic                    reset_i,
  input  logic                    start_i,
  input  adc_ctrl_pkg::spi_req_t  req_i,
  output logic                    done_o,
  output adc_ctrl_pkg::spi_data_t rdata_o,
  output logic                    busy_o,
  output logic                    spi_csn_o,
  output logic                    spi_clk_o,
  output logic                    spi_sdo_o,
  output logic                    spi_sdo_en_o,
  input  logic                    spi_sdi_i
);

  adc_ctrl_pkg::spi_state_e state_q;
  adc_ctrl_pkg::spi_div_t   div_cnt_q;
  adc_ctrl_pkg::spi_bit_t   bit_cnt_q;
  adc_ctrl_pkg::spi_frame_t shift_q;
  adc_ctrl_pkg::spi_data_t  rdata_q;
  logic                     rnw_q;
  logic                     csn_q;
  logic                     sclk_q;
  logic                     sdo_en_q;
  logic                     done_q;
  logic                     half_end;
  logic                     rd_phase;

  assign half_end = (div_cnt_q == adc_ctrl_pkg::SPI_DIV_LAST);
  // Data bits of a read frame
  assign rd_phase = rnw_q && (bit_cnt_q > adc_ctrl_pkg::SPI_RD_TURN);

  // **************************************************
  // Frame sequencing
  // **************************************************
  always_ff @(posedge sys_clk_i) begin
    if (reset_i) begin
      state_q   <= adc_ctrl_pkg::IDLE;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
      shift_q   <= '0;
      rnw_q     <= 1'b0;
      csn_q     <= 1'b1;
      sclk_q    <= 1'b1;
      sdo_en_q  <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        adc_ctrl_pkg::IDLE: begin
          if (start_i) begin
            // First bit goes out with the chip select fall
            state_q   <= adc_ctrl_pkg::SHIFT;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            shift_q   <= adc_ctrl_pkg::spi_frame_t'(req_i);
            rnw_q     <= req_i.rnw;
            csn_q     <= 1'b0;
            sclk_q    <= 1'b0;
            sdo_en_q  <= 1'b1;
          end
        end
        adc_ctrl_pkg::SHIFT: begin
          if (!half_end) begin
            div_cnt_q <= div_cnt_q + 1'b1;
          end else begin
            div_cnt_q <= '0;
            if (!sclk_q) begin
              sclk_q <= 1'b1;
            end else if (bit_cnt_q == adc_ctrl_pkg::SPI_BIT_LAST) begin
              state_q  <= adc_ctrl_pkg::DONE;
              csn_q    <= 1'b1;
              sdo_en_q <= 1'b0;
            end else begin
              // Falling edge, next bit onto the pin
              sclk_q    <= 1'b0;
              bit_cnt_q <= bit_cnt_q + 1'b1;
              shift_q   <= {shift_q[adc_ctrl_pkg::SPI_FRAME_BITS-2:0], 1'b0};
              if (rnw_q && bit_cnt_q == adc_ctrl_pkg::SPI_RD_TURN) begin
                sdo_en_q <= 1'b0;
              end
            end
          end
        end
        adc_ctrl_pkg::DONE: begin
          state_q <= adc_ctrl_pkg::IDLE;
          done_q  <= 1'b1;
        end
        default: begin
          state_q <= adc_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

  // Sample the slave on the rising SPI clock edge
  always_ff @(posedge sys_clk_i) begin
    if (state_q == adc_ctrl_pkg::SHIFT && half_end && !sclk_q && rd_phase) begin
      rdata_q <= {rdata_q[adc_ctrl_pkg::SPI_DATA_BITS-2:0], spi_sdi_i};
    end
  end

  assign done_o       = done_q;
  assign rdata_o      = rdata_q;
  assign busy_o       = (state_q != adc_ctrl_pkg::IDLE);
  assign spi_csn_o    = csn_q;
  assign spi_clk_o    = sclk_q;
  assign spi_sdo_o    = shift_q[adc_ctrl_pkg::SPI_FRAME_BITS-1];
  assign spi_sdo_en_o = sdo_en_q;

endmodule

//--- design/sysref_gen.sv
/*
 * SYSREF generator
 * Produces a free running SYSREF square wave of SYSREF_PERIOD cycles
 * while enabled. Output is held low and the phase restarts when the
 * enable drops.
 */

`timescale 1ns/1ps

module sysref_gen (
  input  logic sys_clk_i,
  input  logic reset_i,
  input  logic sysref_en_i,
  output logic sysref_o
);

  adc_ctrl_pkg::sysref_cnt_t half_cnt_q;
  logic                      sysref_q;

  // Half period counter, output toggles on wrap
  always_ff @(posedge sys_clk_i) begin
    if (reset_i || !sysref_en_i) begin
      half_cnt_q <= '0;
      sysref_q   <= 1'b0;
    end else if (half_cnt_q == adc_ctrl_pkg::SYSREF_HALF_LAST) begin
      half_cnt_q <= '0;
      sysref_q   <= ~sysref_q;
    end else begin
      half_cnt_q <= half_cnt_q + 1'b1;
    end
  end

  assign sysref_o = sysref_q;

endmodule

//--- design/adc_ctrl_pkg.sv
/*
 * ADC control package
 * Register widths, SPI and SYSREF timing constants, the SPI request
 * struct, controller state encodings and the converter init table.
 */

package adc_ctrl_pkg;

  // **************************************************
  // Converter register access
  // **************************************************
  localparam int SPI_ADDR_BITS  = 15;
  localparam int SPI_DATA_BITS  = 8;
  localparam int SPI_FRAME_BITS = 24;

  typedef logic [SPI_ADDR_BITS-1:0]  spi_addr_t;
  typedef logic [SPI_DATA_BITS-1:0]  spi_data_t;
  typedef logic [SPI_FRAME_BITS-1:0] spi_frame_t;

  // Field order matches the wire order of a frame, MSB first
  typedef struct packed {
    logic      rnw;
    spi_addr_t addr;
    spi_data_t wdata;
  } spi_req_t;

  // **************************************************
  // SPI engine timing
  // **************************************************
  localparam int SPI_CLK_DIV = 2;
  localparam int SPI_DIV_W   = (SPI_CLK_DIV > 1) ? $clog2(SPI_CLK_DIV) : 1;
  localparam int SPI_BIT_W   = $clog2(SPI_FRAME_BITS);

  typedef logic [SPI_DIV_W-1:0] spi_div_t;
  typedef logic [SPI_BIT_W-1:0] spi_bit_t;

  localparam spi_div_t SPI_DIV_LAST = spi_div_t'(SPI_CLK_DIV - 1);
  localparam spi_bit_t SPI_BIT_LAST = spi_bit_t'(SPI_FRAME_BITS - 1);
  // Last bit still driven by the master in a read frame
  localparam spi_bit_t SPI_RD_TURN  = spi_bit_t'(SPI_FRAME_BITS - SPI_DATA_BITS - 1);

  // **************************************************
  // SYSREF timing
  // **************************************************
  localparam int SYSREF_PERIOD = 64;
  localparam int SYSREF_HALF   = SYSREF_PERIOD / 2;
  localparam int SYSREF_CNT_W  = $clog2(SYSREF_HALF);

  typedef logic [SYSREF_CNT_W-1:0] sysref_cnt_t;

  localparam sysref_cnt_t SYSREF_HALF_LAST = sysref_cnt_t'(SYSREF_HALF - 1);

  // **************************************************
  // Init table
  // **************************************************
  localparam int INIT_COUNT = 4;
  localparam int INIT_IDX_W = $clog2(INIT_COUNT);

  typedef logic [INIT_IDX_W-1:0] init_idx_t;

  localparam init_idx_t INIT_LAST = init_idx_t'(INIT_COUNT - 1);

  // Soft reset, output mode, test mode off, register transfer
  localparam spi_req_t INIT_TABLE [INIT_COUNT] = '{
    '{1'b0, 15'h0000, 8'h3c},
    '{1'b0, 15'h0014, 8'h01},
    '{1'b0, 15'h000d, 8'h00},
    '{1'b0, 15'h00ff, 8'h01}
  };

  // State encodings
  typedef enum logic [1:0] {IDLE, SHIFT, DONE} spi_state_e;
  typedef enum logic [1:0] {ISSUE, WAIT, FINISHED} init_state_e;

endpackage
